/* ctrl_macros.svh */
`ifndef CTRL_MACROS_SVH
`define CTRL_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////////////////////////

`define CTRL_IRQ_ID_W      5
`define CTRL_CAUSE_W       6
`define CTRL_PC_MUX_W      3
`define CTRL_EXC_PC_MUX_W  2

// fetch stage pc select
`define CTRL_PC_BOOT       3'd0
`define CTRL_PC_JUMP       3'd2
`define CTRL_PC_EXCEPTION  3'd4
`define CTRL_PC_ERET       3'd5

// exception vector select
`define CTRL_EXC_PC_ILLINSN  2'd0
`define CTRL_EXC_PC_ECALL    2'd1
`define CTRL_EXC_PC_IRQ      2'd3

// machine exception codes
`define CTRL_EXC_ILLEGAL     6'h02
`define CTRL_EXC_BREAKPOINT  6'h03
`define CTRL_EXC_ECALL_M     6'h0B

`endif

/* ctrl_pkg.sv */
`include "ctrl_macros.svh"

package ctrl_pkg;

  // main controller states
  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    WAIT_SLEEP,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN
  } ctrl_state_e;

  // one class per ID-stage instruction, after prioritizing
  typedef enum logic [3:0] {
    NONE,
    BRANCH,
    JUMP,
    ECALL,
    ILLEGAL,
    MRET,
    EBREAK,
    CSR_STATUS,
    PIPE_FLUSH
  } insn_class_e;

  // command from the fsm to the trap encoder
  typedef enum logic [2:0] {
    CMD_NONE,
    CMD_BOOT,
    CMD_JUMP,
    CMD_IRQ,
    CMD_ECALL,
    CMD_ILLEGAL,
    CMD_MRET,
    CMD_EBREAK
  } pc_cmd_e;

  // cause word, read as interrupt flag plus id or as plain exception code
  typedef union packed {
    struct packed {
      logic                       is_irq;
      logic [`CTRL_IRQ_ID_W-1:0]  irq_id;
    } irq;
    logic [`CTRL_CAUSE_W-1:0] exc;
  } cause_u;

endpackage

/* ctrl_insn_if.sv */
`timescale 1ns/100ps

// level-valid view of the ID stage instruction, same cycle
interface ctrl_insn_if;

  logic                   valid;
  ctrl_pkg::insn_class_e  cls;
  // ID stage busy with a multicycle op
  logic                   multicycle;
  logic                   branch_in_id;

  // classifier side
  modport classify_mp (output valid, cls, multicycle, branch_in_id);

  // controller fsm side
  modport fsm_mp (input valid, cls, multicycle, branch_in_id);

endinterface

/* ctrl_insn_classify.sv */
`timescale 1ns/100ps

module ctrl_insn_classify (
  input  logic  instr_valid_i,
  input  logic  branch_set_i,
  input  logic  jump_set_i,
  input  logic  ecall_insn_i,
  input  logic  illegal_insn_i,
  input  logic  mret_insn_i,
  input  logic  ebrk_insn_i,
  input  logic  csr_status_i,
  input  logic  pipe_flush_i,
  input  logic  instr_multicycle_i,
  input  logic  branch_in_id_i,

  ctrl_insn_if.classify_mp  insn,

  output logic  deassert_we_o
);

  import ctrl_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // decoder flag priority
  //////////////////////////////////////////////////////////////////////

  // the class is formed even for an invalid slot
  // so FLUSH still sees what sits in ID
  always_comb begin
    if (branch_set_i) begin
      insn.cls = BRANCH;
    end else if (jump_set_i) begin
      insn.cls = JUMP;
    end else if (ecall_insn_i) begin
      insn.cls = ECALL;
    end else if (illegal_insn_i) begin
      insn.cls = ILLEGAL;
    end else if (mret_insn_i) begin
      insn.cls = MRET;
    end else if (ebrk_insn_i) begin
      insn.cls = EBREAK;
    end else if (csr_status_i) begin
      insn.cls = CSR_STATUS;
    end else if (pipe_flush_i) begin
      insn.cls = PIPE_FLUSH;
    end else begin
      insn.cls = NONE;
    end
  end

  // remaining ID stage status
  assign insn.valid        = instr_valid_i;
  assign insn.multicycle   = instr_multicycle_i;
  assign insn.branch_in_id = branch_in_id_i;

  // no register write for an empty slot or a bad opcode
  assign deassert_we_o = ~instr_valid_i | illegal_insn_i;

endmodule

/* ctrl_fsm.sv */
`timescale 1ns/100ps

module ctrl_fsm (
  input  logic  clk,
  input  logic  rst_n,

  input  logic  fetch_enable_i,
  // raw irq line, wakes the core out of wfi
  input  logic  irq_i,
  input  logic  irq_req_ctrl_i,
  input  logic  m_ie_i,
  input  logic  id_ready_i,

  ctrl_insn_if.fsm_mp  insn,

  output ctrl_pkg::pc_cmd_e  pc_cmd_o,
  output logic  instr_req_o,
  output logic  ctrl_busy_o,
  output logic  first_fetch_o,
  output logic  is_decoding_o,
  output logic  halt_if_o,
  output logic  halt_id_o,
  output logic  exc_kill_o
);

  import ctrl_pkg::*;

  ctrl_state_e  state_q;
  ctrl_state_e  state_d;

  // irq may only be taken when ID holds nothing unfinished
  logic  irq_safe;
  logic  irq_take;

  assign irq_safe = ~insn.valid | (~insn.multicycle & ~insn.branch_in_id);
  assign irq_take = irq_req_ctrl_i & m_ie_i;

  //////////////////////////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    pc_cmd_o      = CMD_NONE;
    instr_req_o   = 1'b1;
    ctrl_busy_o   = 1'b1;
    first_fetch_o = 1'b0;
    is_decoding_o = 1'b0;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;
    exc_kill_o    = 1'b0;

    unique case (state_q)
      // out of reset, nothing fetched until enabled
      RESET: begin
        instr_req_o = 1'b0;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end

      // load boot address into the prefetcher
      BOOT_SET: begin
        pc_cmd_o = CMD_BOOT;
        state_d  = FIRST_FETCH;
      end

      // one idle cycle before sleep, pipe is drained
      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        state_d     = SLEEP;
      end

      SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        // wake on the raw line, even if the irq is masked
        if (irq_i) begin
          state_d = FIRST_FETCH;
        end
      end

      FIRST_FETCH: begin
        first_fetch_o = 1'b1;
        // wait out the IF miss
        if (id_ready_i) begin
          state_d = DECODE;
        end
        // pipe was flushed before sleeping, irq can go straight in
        if (irq_take) begin
          state_d   = IRQ_TAKEN;
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
        end
      end

      DECODE: begin
        is_decoding_o = insn.valid;
        if (insn.valid && (insn.cls == BRANCH || insn.cls == JUMP)) begin
          // taken branch or jump, redirect now
          pc_cmd_o = CMD_JUMP;
        end else if (insn.valid && insn.cls != NONE) begin
          // special insn, stop the front end and flush
          state_d   = FLUSH;
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
        end else if (irq_take && irq_safe) begin
          state_d   = IRQ_TAKEN;
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
        end else begin
          // pending but masked irq
          exc_kill_o = irq_req_ctrl_i & irq_safe;
        end
      end

      // single cycle, encoder does the vector jump and acks
      IRQ_TAKEN: begin
        pc_cmd_o = CMD_IRQ;
        state_d  = DECODE;
      end

      // the class still held in ID picks the command
      FLUSH: begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        unique case (insn.cls)
          ECALL:   pc_cmd_o = CMD_ECALL;
          ILLEGAL: pc_cmd_o = CMD_ILLEGAL;
          MRET:    pc_cmd_o = CMD_MRET;
          EBREAK:  pc_cmd_o = CMD_EBREAK;
          default: pc_cmd_o = CMD_NONE;
        endcase
        if (insn.cls == PIPE_FLUSH) begin
          state_d = WAIT_SLEEP;
        end else begin
          state_d = DECODE;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // state register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* ctrl_trap_encoder.sv */
`timescale 1ns/100ps

`include "ctrl_macros.svh"

module ctrl_trap_encoder (
  input  ctrl_pkg::pc_cmd_e  pc_cmd_i,
  input  logic [`CTRL_IRQ_ID_W-1:0]  irq_id_ctrl_i,

  output logic  pc_set_o,
  output logic  csr_save_if_o,
  output logic  csr_save_id_o,
  output logic  csr_save_cause_o,
  output logic  csr_restore_mret_o,
  output logic  irq_ack_o,
  output logic  exc_ack_o,
  output logic [`CTRL_PC_MUX_W-1:0]      pc_mux_o,
  output logic [`CTRL_EXC_PC_MUX_W-1:0]  exc_pc_mux_o,
  output logic [`CTRL_IRQ_ID_W-1:0]      irq_id_o,
  output ctrl_pkg::cause_u  exc_cause_o,
  output ctrl_pkg::cause_u  csr_cause_o
);

  import ctrl_pkg::*;

  // id goes back to the irq controller unchanged
  assign irq_id_o = irq_id_ctrl_i;

  //////////////////////////////////////////////////////////////////////
  // command decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    pc_set_o           = 1'b0;
    pc_mux_o           = `CTRL_PC_BOOT;
    exc_pc_mux_o       = `CTRL_EXC_PC_IRQ;
    csr_save_if_o      = 1'b0;
    csr_save_id_o      = 1'b0;
    csr_save_cause_o   = 1'b0;
    csr_restore_mret_o = 1'b0;
    irq_ack_o          = 1'b0;
    exc_ack_o          = 1'b0;
    exc_cause_o        = '0;
    csr_cause_o        = '0;

    unique case (pc_cmd_i)
      CMD_BOOT: begin
        pc_set_o = 1'b1;
        pc_mux_o = `CTRL_PC_BOOT;
      end
      CMD_JUMP: begin
        pc_set_o = 1'b1;
        pc_mux_o = `CTRL_PC_JUMP;
      end
      CMD_IRQ: begin
        pc_set_o     = 1'b1;
        pc_mux_o     = `CTRL_PC_EXCEPTION;
        exc_pc_mux_o = `CTRL_EXC_PC_IRQ;
        // vector offset from the id, flag only goes to mcause
        exc_cause_o.irq.is_irq = 1'b0;
        exc_cause_o.irq.irq_id = irq_id_ctrl_i;
        csr_cause_o.irq.is_irq = 1'b1;
        csr_cause_o.irq.irq_id = irq_id_ctrl_i;
        csr_save_if_o    = 1'b1;
        csr_save_cause_o = 1'b1;
        irq_ack_o        = 1'b1;
        exc_ack_o        = 1'b1;
      end
      CMD_ECALL: begin
        pc_set_o          = 1'b1;
        pc_mux_o          = `CTRL_PC_EXCEPTION;
        exc_pc_mux_o      = `CTRL_EXC_PC_ECALL;
        exc_cause_o.exc   = `CTRL_EXC_ECALL_M;
        csr_cause_o.exc   = `CTRL_EXC_ECALL_M;
        csr_save_id_o     = 1'b1;
        csr_save_cause_o  = 1'b1;
      end
      CMD_ILLEGAL: begin
        pc_set_o          = 1'b1;
        pc_mux_o          = `CTRL_PC_EXCEPTION;
        exc_pc_mux_o      = `CTRL_EXC_PC_ILLINSN;
        exc_cause_o.exc   = `CTRL_EXC_ILLEGAL;
        csr_cause_o.exc   = `CTRL_EXC_ILLEGAL;
        csr_save_id_o     = 1'b1;
        csr_save_cause_o  = 1'b1;
      end
      // return to mepc, restore mstatus
      CMD_MRET: begin
        pc_set_o           = 1'b1;
        pc_mux_o           = `CTRL_PC_ERET;
        csr_restore_mret_o = 1'b1;
      end
      // cause only, no redirect
      CMD_EBREAK: begin
        exc_cause_o.exc = `CTRL_EXC_BREAKPOINT;
      end
      default: ;
    endcase
  end

endmodule

/* ctrl_top.sv */
`timescale 1ns/100ps

`include "ctrl_macros.svh"

module ctrl_top (
  input  logic  clk,
  input  logic  rst_n,

  input  logic  fetch_enable_i,
  output logic  ctrl_busy_o,
  output logic  first_fetch_o,
  output logic  is_decoding_o,
  output logic  deassert_we_o,

  // decoder flags and ID stage status
  input  logic  instr_valid_i,
  input  logic  branch_set_i,
  input  logic  jump_set_i,
  input  logic  ecall_insn_i,
  input  logic  illegal_insn_i,
  input  logic  mret_insn_i,
  input  logic  ebrk_insn_i,
  input  logic  csr_status_i,
  input  logic  pipe_flush_i,
  input  logic  instr_multicycle_i,
  input  logic  branch_in_id_i,
  input  logic  id_ready_i,

  // prefetcher
  output logic  instr_req_o,
  output logic  pc_set_o,
  output logic [`CTRL_PC_MUX_W-1:0]      pc_mux_o,
  output logic [`CTRL_EXC_PC_MUX_W-1:0]  exc_pc_mux_o,

  // interrupts
  input  logic  irq_i,
  input  logic  irq_req_ctrl_i,
  input  logic [`CTRL_IRQ_ID_W-1:0]  irq_id_ctrl_i,
  input  logic  m_ie_i,
  output logic  irq_ack_o,
  output logic [`CTRL_IRQ_ID_W-1:0]  irq_id_o,

  // exceptions and csr
  output ctrl_pkg::cause_u  exc_cause_o,
  output logic  exc_ack_o,
  output logic  exc_kill_o,
  output logic  csr_save_if_o,
  output logic  csr_save_id_o,
  output ctrl_pkg::cause_u  csr_cause_o,
  output logic  csr_restore_mret_o,
  output logic  csr_save_cause_o,

  output logic  halt_if_o,
  output logic  halt_id_o
);

  import ctrl_pkg::*;

  pc_cmd_e  pc_cmd;

  // classified ID stage instruction
  ctrl_insn_if  insn ();

  //////////////////////////////////////////////////////////////////////
  // submodules
  //////////////////////////////////////////////////////////////////////

  ctrl_insn_classify u_classify (
    .instr_valid_i      (instr_valid_i),
    .branch_set_i       (branch_set_i),
    .jump_set_i         (jump_set_i),
    .ecall_insn_i       (ecall_insn_i),
    .illegal_insn_i     (illegal_insn_i),
    .mret_insn_i        (mret_insn_i),
    .ebrk_insn_i        (ebrk_insn_i),
    .csr_status_i       (csr_status_i),
    .pipe_flush_i       (pipe_flush_i),
    .instr_multicycle_i (instr_multicycle_i),
    .branch_in_id_i     (branch_in_id_i),
    .insn               (insn.classify_mp),
    .deassert_we_o      (deassert_we_o)
  );

  ctrl_fsm u_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .irq_i          (irq_i),
    .irq_req_ctrl_i (irq_req_ctrl_i),
    .m_ie_i         (m_ie_i),
    .id_ready_i     (id_ready_i),
    .insn           (insn.fsm_mp),
    .pc_cmd_o       (pc_cmd),
    .instr_req_o    (instr_req_o),
    .ctrl_busy_o    (ctrl_busy_o),
    .first_fetch_o  (first_fetch_o),
    .is_decoding_o  (is_decoding_o),
    .halt_if_o      (halt_if_o),
    .halt_id_o      (halt_id_o),
    .exc_kill_o     (exc_kill_o)
  );

  ctrl_trap_encoder u_trap_encoder (
    .pc_cmd_i           (pc_cmd),
    .irq_id_ctrl_i      (irq_id_ctrl_i),
    .pc_set_o           (pc_set_o),
    .csr_save_if_o      (csr_save_if_o),
    .csr_save_id_o      (csr_save_id_o),
    .csr_save_cause_o   (csr_save_cause_o),
    .csr_restore_mret_o (csr_restore_mret_o),
    .irq_ack_o          (irq_ack_o),
    .exc_ack_o          (exc_ack_o),
    .pc_mux_o           (pc_mux_o),
    .exc_pc_mux_o       (exc_pc_mux_o),
    .irq_id_o           (irq_id_o),
    .exc_cause_o        (exc_cause_o),
    .csr_cause_o        (csr_cause_o)
  );

endmodule

/* ctrl_assert.sv */
`timescale 1ns/100ps

`include "ctrl_macros.svh"

module ctrl_assert (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       pc_set_o,
  input  logic [`CTRL_PC_MUX_W-1:0]  pc_mux_o,
  input  logic                       irq_ack_o,
  input  logic                       ctrl_busy_o,
  input  logic                       halt_if_o,
  input  ctrl_pkg::ctrl_state_e      state_i
);

  import ctrl_pkg::*;

  // an acked irq always redirects to the exception vector
  irq_ack_redirects: assert property (@(posedge clk) disable iff (!rst_n)
    irq_ack_o |-> (pc_set_o && pc_mux_o == `CTRL_PC_EXCEPTION))
    else $error("irq_ack_o without exception pc_set_o");

  // idle core keeps the fetch stage halted
  idle_halts_if: assert property (@(posedge clk) disable iff (!rst_n)
    !ctrl_busy_o |-> halt_if_o)
    else $error("ctrl_busy_o low while halt_if_o low");

  // nothing is fetched before boot
  no_pc_set_in_reset: assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == RESET) |-> !pc_set_o)
    else $error("pc_set_o in reset state");

endmodule

bind ctrl_top ctrl_assert u_assert (
  .clk         (clk),
  .rst_n       (rst_n),
  .pc_set_o    (pc_set_o),
  .pc_mux_o    (pc_mux_o),
  .irq_ack_o   (irq_ack_o),
  .ctrl_busy_o (ctrl_busy_o),
  .halt_if_o   (halt_if_o),
  .state_i     (u_fsm.state_q)
);

/* tb_ctrl_top.sv */
`timescale 1ns/100ps

`include "ctrl_macros.svh"

module tb_ctrl_top;

  import ctrl_pkg::*;

  // cycles any single wait may take
  localparam int TIMEOUT = 20;

  // what wait_for looks for
  localparam int SEL_PC_SET      = 0;
  localparam int SEL_IRQ_ACK     = 1;
  localparam int SEL_FIRST_FETCH = 2;
  localparam int SEL_IDLE        = 3;
  localparam int SEL_DECODING    = 4;
  localparam int SEL_BREAKPOINT  = 5;

  logic        clk, rst_n;
  logic        fetch_enable_i, ctrl_busy_o, first_fetch_o, is_decoding_o, deassert_we_o;
  logic        instr_valid_i, branch_set_i, jump_set_i, ecall_insn_i, illegal_insn_i;
  logic        mret_insn_i, ebrk_insn_i, csr_status_i, pipe_flush_i;
  logic        instr_multicycle_i, branch_in_id_i, id_ready_i;
  logic        instr_req_o, pc_set_o;
  logic [2:0]  pc_mux_o;
  logic [1:0]  exc_pc_mux_o;
  logic        irq_i, irq_req_ctrl_i, m_ie_i, irq_ack_o;
  logic [4:0]  irq_id_ctrl_i, irq_id_o;
  cause_u      exc_cause_o, csr_cause_o;
  logic        exc_ack_o, exc_kill_o, csr_save_if_o, csr_save_id_o;
  logic        csr_restore_mret_o, csr_save_cause_o, halt_if_o, halt_id_o;

  int          mismatches;
  int          timeouts;
  integer      seed;

  ctrl_top UUT (.*);

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic log_mismatch(input string msg);
    mismatches++;
    $display("FAIL @%0t: %s", $time, msg);
  endtask

  function automatic bit cond_met(input int sel);
    case (sel)
      SEL_PC_SET:      cond_met = pc_set_o;
      SEL_IRQ_ACK:     cond_met = irq_ack_o;
      SEL_FIRST_FETCH: cond_met = first_fetch_o;
      SEL_IDLE:        cond_met = ~ctrl_busy_o;
      SEL_DECODING:    cond_met = is_decoding_o;
      SEL_BREAKPOINT:  cond_met = (exc_cause_o.exc == `CTRL_EXC_BREAKPOINT);
      default:         cond_met = 1'b0;
    endcase
  endfunction

  // one sample per cycle just after the falling edge
  task automatic wait_for(input int sel, input string what, input int max_cycles);
    int n;
    bit seen;
    seen = 1'b0;
    n = 0;
    while (!seen && n < max_cycles) begin
      @(negedge clk);
      #1;
      seen = cond_met(sel);
      n++;
    end
    if (!seen) begin
      timeouts++;
      $display("timeout at %0t: no %s within %0d cycles", $time, what, max_cycles);
    end
  endtask

  task automatic clear_decoder_flags();
    branch_set_i   = 1'b0;
    jump_set_i     = 1'b0;
    ecall_insn_i   = 1'b0;
    illegal_insn_i = 1'b0;
    mret_insn_i    = 1'b0;
    ebrk_insn_i    = 1'b0;
    csr_status_i   = 1'b0;
    pipe_flush_i   = 1'b0;
  endtask

  // plain valid insn in ID so the controller settles in decode
  task automatic goto_decode();
    @(negedge clk);
    clear_decoder_flags();
    instr_valid_i = 1'b1;
    wait_for(SEL_DECODING, "is_decoding_o", TIMEOUT);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_and_boot();
    @(negedge clk);
    #1;
    if (instr_req_o !== 1'b0) log_mismatch("instr_req_o high in reset state");
    if (pc_set_o !== 1'b0) log_mismatch("pc_set_o high in reset state");
    if (ctrl_busy_o !== 1'b1) log_mismatch("ctrl_busy_o low in reset state");
    if ({irq_ack_o, exc_ack_o, csr_save_if_o, csr_save_id_o, csr_save_cause_o,
         csr_restore_mret_o} !== 6'b0) log_mismatch("strobe high in reset state");
    @(negedge clk);
    fetch_enable_i = 1'b1;
    wait_for(SEL_PC_SET, "boot pc_set_o", TIMEOUT);
    if (pc_mux_o !== `CTRL_PC_BOOT) log_mismatch("boot pc_mux_o wrong");
    @(negedge clk);
    #1;
    if (first_fetch_o !== 1'b1) log_mismatch("first_fetch_o low after boot");
  endtask

  task automatic branch_and_jump();
    goto_decode();
    @(negedge clk);
    branch_set_i = 1'b1;
    #1;
    if (pc_set_o !== 1'b1) log_mismatch("no pc_set_o on branch");
    if (pc_mux_o !== `CTRL_PC_JUMP) log_mismatch("branch pc_mux_o wrong");
    if (deassert_we_o !== 1'b0) log_mismatch("deassert_we_o on branch");
    @(negedge clk);
    branch_set_i = 1'b0;
    jump_set_i   = 1'b1;
    #1;
    if (pc_set_o !== 1'b1) log_mismatch("no pc_set_o on jump");
    if (pc_mux_o !== `CTRL_PC_JUMP) log_mismatch("jump pc_mux_o wrong");
    if (deassert_we_o !== 1'b0) log_mismatch("deassert_we_o on jump");
    @(negedge clk);
    jump_set_i = 1'b0;
  endtask

  task automatic ecall_and_illegal();
    goto_decode();
    @(negedge clk);
    ecall_insn_i = 1'b1;
    #1;
    // front end stops in the same cycle the flushing insn is decoded
    if (halt_if_o !== 1'b1) log_mismatch("no halt_if_o on ecall in decode");
    if (halt_id_o !== 1'b1) log_mismatch("no halt_id_o on ecall in decode");
    wait_for(SEL_PC_SET, "ecall pc_set_o", TIMEOUT);
    if (pc_mux_o !== `CTRL_PC_EXCEPTION) log_mismatch("ecall pc_mux_o wrong");
    if (exc_pc_mux_o !== `CTRL_EXC_PC_ECALL) log_mismatch("ecall vector wrong");
    if (exc_cause_o.exc !== `CTRL_EXC_ECALL_M) log_mismatch("ecall exc_cause_o wrong");
    if (csr_cause_o.exc !== `CTRL_EXC_ECALL_M) log_mismatch("ecall csr_cause_o wrong");
    if (csr_save_id_o !== 1'b1) log_mismatch("ecall without csr_save_id_o");
    @(negedge clk);
    ecall_insn_i   = 1'b0;
    illegal_insn_i = 1'b1;
    #1;
    // write enable drops as soon as the bad opcode sits in ID
    if (deassert_we_o !== 1'b1) log_mismatch("no deassert_we_o on illegal insn");
    wait_for(SEL_PC_SET, "illegal pc_set_o", TIMEOUT);
    if (pc_mux_o !== `CTRL_PC_EXCEPTION) log_mismatch("illegal pc_mux_o wrong");
    if (exc_pc_mux_o !== `CTRL_EXC_PC_ILLINSN) log_mismatch("illegal vector wrong");
    if (exc_cause_o.exc !== `CTRL_EXC_ILLEGAL) log_mismatch("illegal exc_cause_o wrong");
    if (csr_cause_o.exc !== `CTRL_EXC_ILLEGAL) log_mismatch("illegal csr_cause_o wrong");
    if (csr_save_id_o !== 1'b1) log_mismatch("illegal without csr_save_id_o");
    @(negedge clk);
    illegal_insn_i = 1'b0;
  endtask

  task automatic mret_and_ebreak();
    goto_decode();
    @(negedge clk);
    mret_insn_i = 1'b1;
    wait_for(SEL_PC_SET, "mret pc_set_o", TIMEOUT);
    if (pc_mux_o !== `CTRL_PC_ERET) log_mismatch("mret pc_mux_o wrong");
    if (csr_restore_mret_o !== 1'b1) log_mismatch("mret without csr_restore_mret_o");
    @(negedge clk);
    mret_insn_i = 1'b0;
    ebrk_insn_i = 1'b1;
    wait_for(SEL_BREAKPOINT, "breakpoint cause", TIMEOUT);
    // cause only so the pc stays where it is
    if (pc_set_o !== 1'b0) log_mismatch("pc_set_o on ebreak");
    @(negedge clk);
    ebrk_insn_i = 1'b0;
  endtask

  task automatic irq_entry();
    int rnd;
    int n;
    logic [4:0] id;
    goto_decode();
    repeat (2) begin
      @(negedge clk);
      rnd = $random(seed);
      id  = rnd[4:0];
      m_ie_i         = 1'b1;
      irq_id_ctrl_i  = id;
      irq_req_ctrl_i = 1'b1;
      wait_for(SEL_IRQ_ACK, "irq_ack_o", TIMEOUT);
      if (irq_id_o !== id) log_mismatch("irq_id_o differs from request id");
      if (csr_cause_o.irq.is_irq !== 1'b1) log_mismatch("csr_cause_o irq flag clear");
      if (csr_cause_o.irq.irq_id !== id) log_mismatch("csr_cause_o irq id wrong");
      if (exc_cause_o.irq.is_irq !== 1'b0) log_mismatch("exc_cause_o irq flag set");
      if (exc_cause_o.irq.irq_id !== id) log_mismatch("exc_cause_o irq id wrong");
      if (pc_set_o !== 1'b1) log_mismatch("no pc_set_o on irq entry");
      if (pc_mux_o !== `CTRL_PC_EXCEPTION) log_mismatch("irq pc_mux_o wrong");
      if (exc_pc_mux_o !== `CTRL_EXC_PC_IRQ) log_mismatch("irq vector wrong");
      if ({exc_ack_o, csr_save_if_o, csr_save_cause_o} !== 3'b111)
        log_mismatch("irq entry strobes missing");
      // request drops on the ack and the ack pulse lasts one cycle
      @(negedge clk);
      irq_req_ctrl_i = 1'b0;
      #1;
      if (irq_ack_o !== 1'b0) log_mismatch("irq_ack_o longer than one cycle");
    end
    // masked request is never acked but killed in decode
    @(negedge clk);
    m_ie_i         = 1'b0;
    irq_req_ctrl_i = 1'b1;
    for (n = 0; n < 10; n++) begin
      @(negedge clk);
      #1;
      if (irq_ack_o !== 1'b0) log_mismatch("irq_ack_o with m_ie_i low");
      if (exc_kill_o !== 1'b1) log_mismatch("exc_kill_o low for masked irq");
    end
    @(negedge clk);
    irq_req_ctrl_i = 1'b0;
  endtask

  task automatic wfi_sleep_wake();
    goto_decode();
    @(negedge clk);
    pipe_flush_i = 1'b1;
    wait_for(SEL_IDLE, "ctrl_busy_o low", TIMEOUT);
    if (instr_req_o !== 1'b0) log_mismatch("instr_req_o high while asleep");
    if (halt_if_o !== 1'b1) log_mismatch("halt_if_o low while asleep");
    if (halt_id_o !== 1'b1) log_mismatch("halt_id_o low while asleep");
    @(negedge clk);
    pipe_flush_i = 1'b0;
    #1;
    // still asleep until the raw line rises
    if (ctrl_busy_o !== 1'b0) log_mismatch("core left sleep without irq_i");
    // raw line wakes the core without any irq request
    @(negedge clk);
    irq_i = 1'b1;
    wait_for(SEL_FIRST_FETCH, "first_fetch_o after wake", TIMEOUT);
    @(negedge clk);
    irq_i = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed               = 25358;
    mismatches         = 0;
    timeouts           = 0;
    rst_n              = 1'b0;
    fetch_enable_i     = 1'b0;
    instr_valid_i      = 1'b0;
    clear_decoder_flags();
    instr_multicycle_i = 1'b0;
    branch_in_id_i     = 1'b0;
    id_ready_i         = 1'b1;
    irq_i              = 1'b0;
    irq_req_ctrl_i     = 1'b0;
    irq_id_ctrl_i      = '0;
    m_ie_i             = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    reset_and_boot();
    branch_and_jump();
    ecall_and_illegal();
    mret_and_ebreak();
    irq_entry();
    wfi_sleep_wake();

    $display("mismatches %0d, timeouts %0d", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+.
ctrl_pkg.sv
ctrl_insn_if.sv
ctrl_insn_classify.sv
ctrl_fsm.sv
ctrl_trap_encoder.sv
ctrl_top.sv
ctrl_assert.sv
tb_ctrl_top.sv

/* Makefile */
# Verilator build and run of the controller testbench

VERILATOR ?= verilator
TOP       ?= tb_ctrl_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
FAIL_MSG  ?= sim failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS FAIL_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
